// File: hdl/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Data SRAM byte address width, 4 KiB
`define SOC_SRAM_AW 12

`define SOC_GPIO_WIDTH 16

// Region nibble in address bits 31..28
`define SOC_SRAM_REGION 4'h2
`define SOC_GPIO_REGION 4'h4

// GPIO register offsets
`define SOC_GPIO_DATAOUT 4'h0
`define SOC_GPIO_DATAIN 4'h4
`define SOC_GPIO_INTEN 4'h8
`define SOC_GPIO_INTSTAT 4'hC

`endif

// File: hdl/ahb_pkg.sv
package ahb_pkg;

	typedef logic [31:0] haddr_t;  // Byte address
	typedef logic [31:0] hdata_t;  // Read and write data
	typedef logic [1:0]  htrans_t; // IDLE, BUSY, NONSEQ, SEQ
	typedef logic [2:0]  hsize_t;  // Byte, halfword, word

	// Default slave answering unmapped transfers
	typedef enum logic [1:0] {
		ERR_IDLE,
		ERR_FIRST,  // HREADY low, HRESP high
		ERR_SECOND  // HREADY high, HRESP high
	} err_state_t;

endpackage

// File: hdl/soc_pkg.sv
`include "soc_defs.svh"

package soc_pkg;

	// One-hot data-phase owner
	// bit 0 is the SRAM, bit 1 the GPIO, zero means none
	typedef logic [1:0] slave_sel_t;

	typedef logic [`SOC_GPIO_WIDTH-1:0] gpio_port_t; // One bit per pin

endpackage

// File: hdl/ahb_sram.sv
`timescale 1ns/1ps

module ahb_sram import ahb_pkg::*; #(
	parameter int AW = 12
) (
	input  logic          hclk_i,
	input  logic          rst_n_i,
	input  logic          hsel_i,
	input  logic          hready_i,
	input  htrans_t       htrans_i,
	input  logic          hwrite_i,
	input  hsize_t        hsize_i,
	input  logic [AW-1:0] haddr_i,
	input  hdata_t        hwdata_i,
	output logic          hreadyout_o,
	output hdata_t        hrdata_o
);

	localparam int WORDS = 2 ** (AW - 2);

	hdata_t        mem [WORDS];
	logic          accept;
	logic          wr_pend;
	logic [AW-1:0] wr_addr;
	hsize_t        wr_size;
	logic [3:0]    wr_lanes;
	logic [AW-3:0] rd_index;
	hdata_t        rd_word;
	hdata_t        rdata_q;

	assign accept   = hsel_i && hready_i && htrans_i[1];
	assign rd_index = haddr_i[AW-1:2];

	always_ff @(posedge hclk_i) begin
		if (!rst_n_i) begin
			wr_pend <= 1'b0;
		end else if (hready_i) begin
			wr_pend <= accept && hwrite_i;
		end
	end

	always_ff @(posedge hclk_i) begin
		if (accept) begin
			wr_addr <= haddr_i;
			wr_size <= hsize_i;
		end
	end

	// Little-endian lanes from the low address bits
	always_comb begin
		case (wr_size[1:0])
			2'b00:   wr_lanes = 4'b0001 << wr_addr[1:0];
			2'b01:   wr_lanes = 4'b0011 << {wr_addr[1], 1'b0};
			default: wr_lanes = 4'b1111;
		endcase
	end

	always_ff @(posedge hclk_i) begin
		if (wr_pend && hready_i) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_lanes[i]) begin
					mem[wr_addr[AW-1:2]][8*i +: 8] <= hwdata_i[8*i +: 8];
				end
			end
		end
	end

	// Forward lanes still being written by the previous data phase
	always_comb begin
		rd_word = mem[rd_index];
		for (int i = 0; i < 4; i++) begin
			if (wr_pend && wr_lanes[i] && wr_addr[AW-1:2] == rd_index) begin
				rd_word[8*i +: 8] = hwdata_i[8*i +: 8];
			end
		end
	end

	always_ff @(posedge hclk_i) begin
		if (accept && !hwrite_i) begin
			rdata_q <= rd_word;
		end
	end

	assign hrdata_o    = rdata_q;
	assign hreadyout_o = 1'b1; // Zero wait states

	// Master keeps halfword and word transfers naturally aligned
	assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		accept |-> (hsize_i != 3'b001 || !haddr_i[0]) &&
			(hsize_i != 3'b010 || haddr_i[1:0] == 2'b00));

endmodule

// File: hdl/ahb_gpio.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module ahb_gpio import ahb_pkg::*, soc_pkg::*; (
	input  logic       hclk_i,
	input  logic       rst_n_i,
	input  logic       hsel_i,
	input  logic       hready_i,
	input  htrans_t    htrans_i,
	input  logic       hwrite_i,
	input  logic [3:0] haddr_i,
	input  hdata_t     hwdata_i,
	input  gpio_port_t gpio_in_i,
	output logic       hreadyout_o,
	output hdata_t     hrdata_o,
	output gpio_port_t gpio_out_o,
	output logic       irq_o
);

	logic       accept;
	logic       wr_pend;
	logic       wr_en;
	logic [3:0] addr_q;
	gpio_port_t wdata;
	gpio_port_t sync1_q;
	gpio_port_t sync2_q;
	gpio_port_t prev_q;
	gpio_port_t rise;
	gpio_port_t stat_clr;
	gpio_port_t dataout_q;
	gpio_port_t inten_q;
	gpio_port_t stat_q;
	logic       irq_q;

	assign accept = hsel_i && hready_i && htrans_i[1];
	assign wr_en  = wr_pend && hready_i;
	assign wdata  = hwdata_i[`SOC_GPIO_WIDTH-1:0]; // Word registers ignore the size

	always_ff @(posedge hclk_i) begin
		if (!rst_n_i) begin
			wr_pend <= 1'b0;
		end else if (hready_i) begin
			wr_pend <= accept && hwrite_i;
		end
	end

	always_ff @(posedge hclk_i) begin
		if (accept) begin
			addr_q <= haddr_i;
		end
	end

	// Two-flop synchronizer followed by edge detect
	always_ff @(posedge hclk_i) begin
		if (!rst_n_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end else begin
			sync1_q <= gpio_in_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
		end
	end

	assign rise     = sync2_q & ~prev_q;
	assign stat_clr = (wr_en && addr_q == `SOC_GPIO_INTSTAT) ? wdata : '0; // Write one to clear

	always_ff @(posedge hclk_i) begin
		if (!rst_n_i) begin
			dataout_q <= '0;
			inten_q   <= '0;
			stat_q    <= '0;
			irq_q     <= 1'b0;
		end else begin
			if (wr_en && addr_q == `SOC_GPIO_DATAOUT) begin
				dataout_q <= wdata;
			end
			if (wr_en && addr_q == `SOC_GPIO_INTEN) begin
				inten_q <= wdata;
			end
			stat_q <= (stat_q & ~stat_clr) | rise; // New edge beats the clear
			irq_q  <= |(stat_q & inten_q);
		end
	end

	always_comb begin
		case (addr_q)
			`SOC_GPIO_DATAOUT: hrdata_o = hdata_t'(dataout_q);
			`SOC_GPIO_DATAIN:  hrdata_o = hdata_t'(sync2_q);
			`SOC_GPIO_INTEN:   hrdata_o = hdata_t'(inten_q);
			`SOC_GPIO_INTSTAT: hrdata_o = hdata_t'(stat_q);
			default:           hrdata_o = '0;
		endcase
	end

	assign hreadyout_o = 1'b1;
	assign gpio_out_o  = dataout_q;
	assign irq_o       = irq_q;

	// Zero written to INTEN holds irq_o low two cycles later
	assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		$past(wr_en && addr_q == `SOC_GPIO_INTEN && wdata == '0, 2) |-> !irq_o);

endmodule

// File: hdl/ahb_decoder_mux.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module ahb_decoder_mux import ahb_pkg::*, soc_pkg::*; (
	input  logic    hclk_i,
	input  logic    rst_n_i,
	input  haddr_t  haddr_i,
	input  htrans_t htrans_i,
	input  hdata_t  sram_hrdata_i,
	input  logic    sram_hreadyout_i,
	input  hdata_t  gpio_hrdata_i,
	input  logic    gpio_hreadyout_i,
	output logic    sram_hsel_o,
	output logic    gpio_hsel_o,
	output logic    hready_o,
	output logic    hresp_o,
	output hdata_t  hrdata_o
);

	logic [3:0] region;
	logic       trans_valid;
	logic       sram_hit;
	logic       gpio_hit;
	logic       unmapped;
	slave_sel_t sel_q;
	err_state_t err_state;
	err_state_t err_next;

	assign region      = haddr_i[31:28];
	assign trans_valid = htrans_i[1]; // NONSEQ or SEQ
	assign sram_hit    = (region == `SOC_SRAM_REGION);
	assign gpio_hit    = (region == `SOC_GPIO_REGION);
	assign unmapped    = trans_valid && !sram_hit && !gpio_hit;

	// Slaves qualify with htrans themselves
	assign sram_hsel_o = sram_hit;
	assign gpio_hsel_o = gpio_hit;

	always_ff @(posedge hclk_i) begin
		if (!rst_n_i) begin
			sel_q <= '0;
		end else if (hready_o) begin
			sel_q <= {gpio_hit, sram_hit} & {2{trans_valid}}; // Owner of next data phase
		end
	end

	// Default slave answering with a two-cycle ERROR response
	always_comb begin
		err_next = err_state;
		case (err_state)
			ERR_IDLE: begin
				if (hready_o && unmapped) begin
					err_next = ERR_FIRST;
				end
			end
			ERR_FIRST: err_next = ERR_SECOND;
			ERR_SECOND: err_next = unmapped ? ERR_FIRST : ERR_IDLE; // Next address accepted here
			default: err_next = ERR_IDLE;
		endcase
	end

	always_ff @(posedge hclk_i) begin
		if (!rst_n_i) begin
			err_state <= ERR_IDLE;
		end else begin
			err_state <= err_next;
		end
	end

	always_comb begin
		case (err_state)
			ERR_FIRST:  hready_o = 1'b0;
			ERR_SECOND: hready_o = 1'b1;
			default: begin
				case (sel_q)
					2'b01:   hready_o = sram_hreadyout_i;
					2'b10:   hready_o = gpio_hreadyout_i;
					default: hready_o = 1'b1; // Idle data phase
				endcase
			end
		endcase
	end

	assign hresp_o = (err_state != ERR_IDLE);

	always_comb begin
		case (sel_q)
			2'b01:   hrdata_o = sram_hrdata_i;
			2'b10:   hrdata_o = gpio_hrdata_i;
			default: hrdata_o = '0;
		endcase
	end

	// The wait cycle ends in the completing ERROR cycle with no slave owning the data phase
	assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		err_state == ERR_FIRST |=> err_state == ERR_SECOND && sel_q == '0);

endmodule

// File: hdl/soc_top.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_top import ahb_pkg::*, soc_pkg::*; (
	input  logic       hclk_i,
	input  logic       rst_n_i,
	input  haddr_t     haddr_i,
	input  htrans_t    htrans_i,
	input  logic       hwrite_i,
	input  hsize_t     hsize_i,
	input  hdata_t     hwdata_i,
	input  gpio_port_t gpio_in_i,
	output hdata_t     hrdata_o,
	output logic       hready_o,
	output logic       hresp_o,
	output gpio_port_t gpio_out_o,
	output logic       irq_o
);

	logic   sram_hsel;
	logic   sram_hreadyout;
	hdata_t sram_hrdata;
	logic   gpio_hsel;
	logic   gpio_hreadyout;
	hdata_t gpio_hrdata;

	ahb_decoder_mux ahb_decoder_mux_instance (
		.hclk_i           (hclk_i),
		.rst_n_i          (rst_n_i),
		.haddr_i          (haddr_i),
		.htrans_i         (htrans_i),
		.sram_hrdata_i    (sram_hrdata),
		.sram_hreadyout_i (sram_hreadyout),
		.gpio_hrdata_i    (gpio_hrdata),
		.gpio_hreadyout_i (gpio_hreadyout),
		.sram_hsel_o      (sram_hsel),
		.gpio_hsel_o      (gpio_hsel),
		.hready_o         (hready_o), // Also fed back to the slaves
		.hresp_o          (hresp_o),
		.hrdata_o         (hrdata_o)
	);

	ahb_sram #(.AW(`SOC_SRAM_AW)) data_sram_instance (
		.hclk_i      (hclk_i),
		.rst_n_i     (rst_n_i),
		.hsel_i      (sram_hsel),
		.hready_i    (hready_o),
		.htrans_i    (htrans_i),
		.hwrite_i    (hwrite_i),
		.hsize_i     (hsize_i),
		.haddr_i     (haddr_i[`SOC_SRAM_AW-1:0]),
		.hwdata_i    (hwdata_i),
		.hreadyout_o (sram_hreadyout),
		.hrdata_o    (sram_hrdata)
	);

	ahb_gpio ahb_gpio_instance (
		.hclk_i      (hclk_i),
		.rst_n_i     (rst_n_i),
		.hsel_i      (gpio_hsel),
		.hready_i    (hready_o),
		.htrans_i    (htrans_i),
		.hwrite_i    (hwrite_i),
		.haddr_i     (haddr_i[3:0]), // Register offset only
		.hwdata_i    (hwdata_i),
		.gpio_in_i   (gpio_in_i),
		.hreadyout_o (gpio_hreadyout),
		.hrdata_o    (gpio_hrdata),
		.gpio_out_o  (gpio_out_o),
		.irq_o       (irq_o)
	);

endmodule

// File: tests/soc_tb_tasks.svh
function automatic haddr_t sram_addr(int unsigned byte_off);
	return {`SOC_SRAM_REGION, 28'(byte_off)};
endfunction

function automatic haddr_t gpio_addr(logic [3:0] offset);
	return {`SOC_GPIO_REGION, 24'h0, offset};
endfunction

// Little-endian lane replacement
function automatic hdata_t merge_lanes(hdata_t old_word, hdata_t new_word, int first, int count);
	hdata_t result;
	result = old_word;
	for (int i = first; i < first + count; i++) begin
		result[8*i +: 8] = new_word[8*i +: 8];
	end
	return result;
endfunction

task automatic check_data(input string name, input hdata_t got, input hdata_t exp);
	if (got !== exp) begin
		$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
		fail_run();
	end
endtask

task automatic check_port(input string name, input gpio_port_t got, input gpio_port_t exp);
	if (got !== exp) begin
		$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
		fail_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
		fail_run();
	end
endtask

task automatic ahb_write(input haddr_t addr, input hsize_t size, input hdata_t data,
		output logic resp);
	@(negedge hclk);
	haddr  = addr;
	htrans = HTRANS_NONSEQ;
	hwrite = 1'b1;
	hsize  = size;
	while (!hready) begin
		@(negedge hclk); // Hold the address phase
	end
	@(negedge hclk);
	htrans = HTRANS_IDLE;
	hwrite = 1'b0;
	hwdata = data;
	if (hresp) begin
		check_bit("hready_o in first ERROR cycle", hready, 1'b0);
	end
	while (!hready) begin
		@(negedge hclk);
	end
	resp = hresp;
	@(posedge hclk); // Data phase ends here
endtask

task automatic ahb_read(input haddr_t addr, input hsize_t size, output hdata_t data,
		output logic resp);
	@(negedge hclk);
	haddr  = addr;
	htrans = HTRANS_NONSEQ;
	hwrite = 1'b0;
	hsize  = size;
	while (!hready) begin
		@(negedge hclk);
	end
	@(negedge hclk);
	htrans = HTRANS_IDLE;
	if (hresp) begin
		check_bit("hready_o in first ERROR cycle", hready, 1'b0);
	end
	while (!hready) begin
		@(negedge hclk);
	end
	data = hrdata;
	resp = hresp;
	@(posedge hclk);
endtask

task automatic write_ok(input haddr_t addr, input hsize_t size, input hdata_t data);
	logic resp;
	ahb_write(addr, size, data, resp);
	check_bit("hresp_o", resp, 1'b0);
endtask

task automatic read_ok(input haddr_t addr, output hdata_t data);
	logic resp;
	ahb_read(addr, SIZE_WORD, data, resp);
	check_bit("hresp_o", resp, 1'b0);
endtask

task automatic apply_pins(input gpio_port_t value);
	@(negedge hclk);
	gpio_in = value;
	repeat (6) @(negedge hclk); // Synchronizer, edge detect and irq register
endtask

task automatic test_reset_values();
	hdata_t rdata;
	@(negedge hclk);
	check_bit("hready_o", hready, 1'b1);
	check_bit("hresp_o", hresp, 1'b0);
	check_bit("irq_o", irq, 1'b0);
	check_port("gpio_out_o", gpio_out, '0);
	read_ok(gpio_addr(`SOC_GPIO_INTSTAT), rdata);
	check_data("INTSTAT", rdata, 32'h0);
endtask

task automatic test_word_writes();
	int unsigned index [16];
	hdata_t rdata;
	for (int n = 0; n < 16; n++) begin
		index[n] = $urandom_range(SRAM_WORDS - 1, 0);
		sram_model[index[n]] = $urandom();
		write_ok(sram_addr(index[n] * 4), SIZE_WORD, sram_model[index[n]]);
	end
	for (int n = 0; n < 16; n++) begin
		read_ok(sram_addr(index[n] * 4), rdata);
		check_data("hrdata_o", rdata, sram_model[index[n]]);
	end
endtask

task automatic test_byte_lanes();
	int unsigned index;
	hdata_t wdata;
	hdata_t rdata;
	index = $urandom_range(SRAM_WORDS - 1, 0);
	wdata = $urandom();
	write_ok(sram_addr(index * 4), SIZE_WORD, wdata);
	sram_model[index] = wdata;
	for (int lane = 0; lane < 4; lane++) begin
		wdata = $urandom(); // Other lanes carry noise
		write_ok(sram_addr(index * 4 + lane), SIZE_BYTE, wdata);
		sram_model[index] = merge_lanes(sram_model[index], wdata, lane, 1);
		read_ok(sram_addr(index * 4), rdata);
		check_data("hrdata_o after byte write", rdata, sram_model[index]);
	end
	for (int lane = 0; lane < 4; lane += 2) begin
		wdata = $urandom();
		write_ok(sram_addr(index * 4 + lane), SIZE_HALF, wdata);
		sram_model[index] = merge_lanes(sram_model[index], wdata, lane, 2);
		read_ok(sram_addr(index * 4), rdata);
		check_data("hrdata_o after halfword write", rdata, sram_model[index]);
	end
endtask

task automatic test_gpio_io();
	hdata_t wdata;
	hdata_t rdata;
	gpio_port_t pins;
	wdata = $urandom(); // Upper bits must be dropped
	pins  = gpio_port_t'(wdata);
	write_ok(gpio_addr(`SOC_GPIO_DATAOUT), SIZE_WORD, wdata);
	@(negedge hclk);
	check_port("gpio_out_o", gpio_out, pins);
	read_ok(gpio_addr(`SOC_GPIO_DATAOUT), rdata);
	check_data("DATAOUT", rdata, hdata_t'(pins));
	pins = gpio_port_t'($urandom());
	@(negedge hclk);
	gpio_in = pins;
	repeat (3) @(negedge hclk);
	read_ok(gpio_addr(`SOC_GPIO_DATAIN), rdata);
	check_data("DATAIN", rdata, hdata_t'(pins));
endtask

task automatic test_gpio_irq();
	gpio_port_t mask;
	gpio_port_t pins;
	hdata_t rdata;
	mask = (gpio_port_t'($urandom()) | 16'h0001) & 16'h7FFF;
	apply_pins('0);
	write_ok(gpio_addr(`SOC_GPIO_INTEN), SIZE_WORD, 32'h0);
	write_ok(gpio_addr(`SOC_GPIO_INTSTAT), SIZE_WORD, 32'hFFFF); // Drop earlier edges
	write_ok(gpio_addr(`SOC_GPIO_INTEN), SIZE_WORD, hdata_t'(mask));
	pins = (gpio_port_t'($urandom()) & mask) | 16'h0001; // Enabled pins only
	apply_pins(pins);
	read_ok(gpio_addr(`SOC_GPIO_INTSTAT), rdata);
	check_data("INTSTAT", rdata, hdata_t'(pins & mask));
	@(negedge hclk);
	check_bit("irq_o", irq, |(pins & mask));
	write_ok(gpio_addr(`SOC_GPIO_INTSTAT), SIZE_WORD, hdata_t'(pins & mask));
	read_ok(gpio_addr(`SOC_GPIO_INTSTAT), rdata);
	check_data("INTSTAT after clear", rdata, 32'h0);
	@(negedge hclk);
	check_bit("irq_o after clear", irq, 1'b0);
	apply_pins('0); // Falling edges leave status alone
	pins = (gpio_port_t'($urandom()) & ~mask) | 16'h8000; // Disabled pins only
	apply_pins(pins);
	read_ok(gpio_addr(`SOC_GPIO_INTSTAT), rdata);
	check_data("INTSTAT disabled pins", rdata, hdata_t'(pins));
	@(negedge hclk);
	check_bit("irq_o disabled pins", irq, 1'b0);
	write_ok(gpio_addr(`SOC_GPIO_INTSTAT), SIZE_WORD, hdata_t'(pins));
endtask

task automatic test_unmapped();
	int unsigned index;
	hdata_t wdata;
	hdata_t rdata;
	logic resp;
	index = $urandom_range(SRAM_WORDS - 1, 0);
	wdata = $urandom();
	write_ok(sram_addr(index * 4), SIZE_WORD, wdata);
	sram_model[index] = wdata;
	ahb_read({4'h8, 28'h10}, SIZE_WORD, rdata, resp);
	check_bit("hresp_o unmapped read", resp, 1'b1);
	ahb_write({4'h8, 28'h20}, SIZE_WORD, $urandom(), resp);
	check_bit("hresp_o unmapped write", resp, 1'b1);
	read_ok(sram_addr(index * 4), rdata);
	check_data("hrdata_o after error", rdata, sram_model[index]);
endtask

// File: tests/soc_tb.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_tb import ahb_pkg::*, soc_pkg::*; ();

	localparam int      TIMEOUT_CYCLES = 2000; // Tests need about 500
	localparam int      SRAM_WORDS     = 2 ** (`SOC_SRAM_AW - 2);
	localparam htrans_t HTRANS_IDLE    = 2'b00;
	localparam htrans_t HTRANS_NONSEQ  = 2'b10;
	localparam hsize_t  SIZE_BYTE      = 3'b000;
	localparam hsize_t  SIZE_HALF      = 3'b001;
	localparam hsize_t  SIZE_WORD      = 3'b010;

	logic       hclk;
	logic       rst_n;
	haddr_t     haddr;
	htrans_t    htrans;
	logic       hwrite;
	hsize_t     hsize;
	hdata_t     hwdata;
	gpio_port_t gpio_in;
	hdata_t     hrdata;
	logic       hready;
	logic       hresp;
	gpio_port_t gpio_out;
	logic       irq;
	int         cycle_count;
	hdata_t     sram_model [SRAM_WORDS]; // Expected SRAM contents

	soc_top uut (
		.hclk_i     (hclk),
		.rst_n_i    (rst_n),
		.haddr_i    (haddr),
		.htrans_i   (htrans),
		.hwrite_i   (hwrite),
		.hsize_i    (hsize),
		.hwdata_i   (hwdata),
		.gpio_in_i  (gpio_in),
		.hrdata_o   (hrdata),
		.hready_o   (hready),
		.hresp_o    (hresp),
		.gpio_out_o (gpio_out),
		.irq_o      (irq)
	);

	initial begin
		hclk = 1'b0;
		forever #2 hclk = ~hclk; // 4 ns period
	end

	initial begin
		cycle_count = 0;
	end

	always @(posedge hclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end
	end

	task automatic fail_run();
		$display("sim failed");
		$fatal(1, "Stopped at the first failure");
	endtask

	`include "soc_tb_tasks.svh"

	initial begin
		void'($urandom(32'h301bcbca));
		rst_n   = 1'b0;
		haddr   = '0;
		htrans  = HTRANS_IDLE;
		hwrite  = 1'b0;
		hsize   = SIZE_WORD;
		hwdata  = '0;
		gpio_in = '0;
		repeat (5) @(posedge hclk);
		@(negedge hclk);
		rst_n = 1'b1;
		test_reset_values();
		test_word_writes();
		test_byte_lanes();
		test_gpio_io();
		test_gpio_irq();
		test_unmapped();
		$display("sim passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
+incdir+tests
hdl/ahb_pkg.sv
hdl/soc_pkg.sv
hdl/ahb_sram.sv
hdl/ahb_gpio.sv
hdl/ahb_decoder_mux.sv
hdl/soc_top.sv
tests/soc_tb.sv

// File: Makefile
TOP       ?= soc_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' filelist.f) $(wildcard hdl/*.svh tests/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) filelist.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f filelist.f --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(OBJ_DIR)
